/* verilog/tcpStreamPkg.sv */
`default_nettype none

package tcpStreamPkg;

	//////////////////////////////////////////////////
	// basic field types
	//////////////////////////////////////////////////

	typedef logic [7:0]  byteT;
	typedef logic [31:0] ipAddrT;
	typedef logic [15:0] portT;
	typedef logic [31:0] seqNumT;
	typedef logic [15:0] lenT;

	// byte counter within one header field group
	typedef logic [5:0]  cntT;

	//////////////////////////////////////////////////
	// ethertype and size constants
	//////////////////////////////////////////////////

	// ethertype decoded in two steps, high byte first
	localparam byteT ETH_TYPE_IPV4_HI = 8'h08;
	localparam byteT ETH_TYPE_IPV4_LO = 8'h00;
	localparam byteT ETH_TYPE_VLAN_HI = 8'h81;

	localparam lenT        IP_TCP_MIN_HDR = 16'd40;	// 20 ip + 20 tcp
	localparam logic [3:0] MIN_HDR_WORDS  = 4'd5;	// ihl and data offset floor

	// field group sizes in bytes
	localparam cntT MAC_BYTES      = 6'd12;	// dst + src mac
	localparam cntT VLAN_BYTES     = 6'd3;	// tag bytes after the 0x81
	localparam cntT IP_FIXED_BYTES = 6'd20;
	localparam cntT TCP_PORT_BYTES = 6'd4;
	localparam cntT TCP_SEQ_BYTES  = 6'd4;
	localparam cntT TCP_ACK_BYTES  = 6'd4;
	localparam cntT TCP_REST_BYTES = 6'd6;	// window, checksum, urgent

	// byte positions inside the fixed ipv4 header
	localparam cntT IP_LEN_HI_POS = 6'd2;
	localparam cntT IP_LEN_LO_POS = 6'd3;
	localparam cntT IP_PROTO_POS  = 6'd9;
	localparam cntT IP_SRC_POS    = 6'd12;
	localparam cntT IP_DST_POS    = 6'd16;

	//////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////

	typedef enum logic [7:0] {
		protoTcp   = 8'd6,
		protoOther = 8'hff	// anything we skip
	} ipProtoT;

	typedef enum logic [5:0] {
		stIdle,
		stMac,
		stEthTypeHi,
		stEthTypeLo,
		stVlan,
		stIpFixed,
		stIpOpt,
		stTcpPorts,
		stTcpSeq,
		stTcpAck,
		stTcpOffset,
		stTcpFlags,
		stTcpRest,
		stTcpOpt,
		stPayload
	} parseStateT;

endpackage

`default_nettype wire

/* verilog/frameParser.sv */
`timescale 1ns/1ps
`default_nettype none

module frameParser (
	input  wire                  CLOCK,
	input  wire                  rst,
	input  wire                  newPkt,
	input  wire                  dataValid,
	input  wire tcpStreamPkg::byteT   data,
	input  wire tcpStreamPkg::ipAddrT srcIp,
	input  wire tcpStreamPkg::ipAddrT dstIp,
	input  wire tcpStreamPkg::portT   srcPort,
	input  wire tcpStreamPkg::portT   dstPort,
	output logic                 payValid,
	output tcpStreamPkg::byteT   payData,
	output logic                 payFirst,
	output logic                 segValid,
	output tcpStreamPkg::seqNumT segSeq,
	output logic                 segSyn,
	output tcpStreamPkg::lenT    segLen
);

	import tcpStreamPkg::*;

	parseStateT state;
	cntT        byteCnt;
	cntT        fieldLen;
	logic       fieldLast;
	logic       hdrDone;

	logic [3:0] ihl;
	logic [3:0] dataOff;
	lenT        totalLen;
	ipProtoT    ipProto;
	seqNumT     seqReg;
	logic       synFlag;

	logic       match;		// running 4-tuple compare
	logic       firstFlag;
	lenT        payLeft;
	lenT        ipOptLen;
	lenT        tcpOptLen;
	lenT        payLen;

	ipAddrT     addrWord;
	byteT       addrByte;
	portT       portWord;
	byteT       portByte;

	//////////////////////////////////////////////////
	// field bookkeeping
	//////////////////////////////////////////////////

	assign ipOptLen  = lenT'({ihl - MIN_HDR_WORDS, 2'b00});
	assign tcpOptLen = lenT'({dataOff - MIN_HDR_WORDS, 2'b00});
	assign payLen    = totalLen - IP_TCP_MIN_HDR - ipOptLen - tcpOptLen;

	always_comb begin
		case (state)
			stMac:      fieldLen = MAC_BYTES;
			stVlan:     fieldLen = VLAN_BYTES;
			stIpFixed:  fieldLen = IP_FIXED_BYTES;
			stIpOpt:    fieldLen = ipOptLen[5:0];
			stTcpPorts: fieldLen = TCP_PORT_BYTES;
			stTcpSeq:   fieldLen = TCP_SEQ_BYTES;
			stTcpAck:   fieldLen = TCP_ACK_BYTES;
			stTcpRest:  fieldLen = TCP_REST_BYTES;
			stTcpOpt:   fieldLen = tcpOptLen[5:0];
			default:    fieldLen = 6'd1;	// single byte fields
		endcase
	end

	assign fieldLast = byteCnt == fieldLen - 1'b1;

	// last byte of the tcp header, with or without options
	assign hdrDone = dataValid && !newPkt && fieldLast &&
		((state == stTcpRest && dataOff == MIN_HDR_WORDS) || state == stTcpOpt);

	// session byte for the current address or port position
	assign addrWord = (byteCnt < IP_DST_POS) ? srcIp : dstIp;
	assign addrByte = addrWord[{~byteCnt[1:0], 3'b000} +: 8];
	assign portWord = byteCnt[1] ? dstPort : srcPort;
	assign portByte = portWord[{~byteCnt[0], 3'b000} +: 8];

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	// newPkt is a pulse ahead of the first mac byte
	always_ff @(posedge CLOCK) begin
		if (rst) begin
			state     <= stIdle;
			byteCnt   <= '0;
			match     <= 1'b0;
			firstFlag <= 1'b0;
			payLeft   <= '0;
			payValid  <= 1'b0;
			segValid  <= 1'b0;
		end else begin
			payValid <= 1'b0;
			segValid <= 1'b0;
			if (newPkt) begin
				state   <= stMac;
				byteCnt <= '0;
				match   <= 1'b1;
			end else if (dataValid && state != stIdle) begin
				byteCnt <= fieldLast ? '0 : byteCnt + 1'b1;
				case (state)
					stMac:       if (fieldLast) state <= stEthTypeHi;
					stEthTypeHi: begin
						if (data == ETH_TYPE_VLAN_HI)
							state <= stVlan;
						else if (data == ETH_TYPE_IPV4_HI)
							state <= stEthTypeLo;
						else
							state <= stIdle;
					end
					stEthTypeLo: state <= (data == ETH_TYPE_IPV4_LO) ? stIpFixed : stIdle;
					stVlan:      if (fieldLast) state <= stEthTypeHi;	// tag done, type again
					stIpFixed: begin
						if (byteCnt >= IP_SRC_POS && data != addrByte)
							match <= 1'b0;
						if (fieldLast) begin
							if (ihl < MIN_HDR_WORDS)
								state <= stIdle;	// malformed
							else if (ihl != MIN_HDR_WORDS)
								state <= stIpOpt;
							else
								state <= (ipProto == protoTcp) ? stTcpPorts : stIdle;
						end
					end
					stIpOpt: begin
						if (fieldLast)
							state <= (ipProto == protoTcp) ? stTcpPorts : stIdle;
					end
					stTcpPorts: begin
						if (data != portByte)
							match <= 1'b0;
						if (fieldLast) state <= stTcpSeq;
					end
					stTcpSeq:    if (fieldLast) state <= stTcpAck;
					stTcpAck:    if (fieldLast) state <= stTcpOffset;
					stTcpOffset: state <= stTcpFlags;
					stTcpFlags:  state <= stTcpRest;
					stTcpRest: begin
						if (fieldLast)
							state <= (dataOff > MIN_HDR_WORDS) ? stTcpOpt : stIdle;
					end
					stTcpOpt: ;	// end handled by hdrDone
					stPayload: begin
						payValid  <= match;
						firstFlag <= 1'b0;
						payLeft   <= payLeft - 1'b1;
						if (payLeft == 16'd1) state <= stIdle;
					end
					default: state <= stIdle;
				endcase

				// header complete, overrides the case above
				if (hdrDone) begin
					segValid <= match;
					if (match && payLen != '0) begin
						state     <= stPayload;
						payLeft   <= payLen;
						firstFlag <= 1'b1;
					end else begin
						state <= stIdle;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// header field capture
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (dataValid && !newPkt) begin
			case (state)
				stIpFixed: begin
					if (byteCnt == '0) ihl <= data[3:0];
					if (byteCnt == IP_LEN_HI_POS) totalLen[15:8] <= data;
					if (byteCnt == IP_LEN_LO_POS) totalLen[7:0] <= data;
					if (byteCnt == IP_PROTO_POS)
						ipProto <= (data == byteT'(protoTcp)) ? protoTcp : protoOther;
				end
				stTcpSeq:    seqReg <= {seqReg[23:0], data};	// msb first
				stTcpOffset: dataOff <= data[7:4];
				stTcpFlags:  synFlag <= data[1];
				default: ;
			endcase
		end
		payData  <= data;
		payFirst <= firstFlag;
		if (hdrDone) begin
			segSeq <= seqReg;
			segSyn <= synFlag;
			segLen <= payLen;
		end
	end

endmodule

`default_nettype wire

/* verilog/payloadFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module payloadFifo #(
	parameter int fifoDepth = 64
) (
	input  wire                CLOCK,
	input  wire                rst,
	input  wire                payValid,
	input  wire tcpStreamPkg::byteT payData,
	input  wire                payFirst,
	input  wire                outReady,
	output logic               outValid,
	output tcpStreamPkg::byteT outData,
	output logic               outFirst,
	output logic               dropped
);

	localparam int ptrWidth = $clog2(fifoDepth);

	// entry is {first tag, data byte}
	logic [8:0]          mem [fifoDepth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth:0]   count;

	logic full;
	logic doWrite;
	logic doRead;

	assign full    = count == (ptrWidth + 1)'(fifoDepth);
	assign doWrite = payValid && !full;
	assign outValid = count != '0;
	assign doRead  = outValid && outReady;

	// head entry stays put until it is read
	assign {outFirst, outData} = mem[rdPtr];

	always_ff @(posedge CLOCK) begin
		if (doWrite)
			mem[wrPtr] <= {payFirst, payData};
	end

	//////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (rst) begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			dropped <= 1'b0;
		end else begin
			if (doWrite) wrPtr <= wrPtr + 1'b1;	// wraps at power of two
			if (doRead)  rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// byte lost, sticky until reset
			if (payValid && full)
				dropped <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/seqTracker.sv */
`timescale 1ns/1ps
`default_nettype none

module seqTracker (
	input  wire                 CLOCK,
	input  wire                 rst,
	input  wire                 segValid,
	input  wire tcpStreamPkg::seqNumT segSeq,
	input  wire                 segSyn,
	input  wire tcpStreamPkg::lenT    segLen,
	output logic                gapped
);

	import tcpStreamPkg::*;

	seqNumT expSeq;		// where the next segment should start
	logic   synSeen;
	logic   seqMiss;

	assign seqMiss = segSeq != expSeq;

	//////////////////////////////////////////////////
	// expected sequence register
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (segValid) begin
			if (segSyn)
				expSeq <= segSeq + 32'd1;	// syn takes one number
			else
				expSeq <= segSeq + seqNumT'(segLen);	// resync after a gap too
		end
	end

	//////////////////////////////////////////////////
	// gap decision
	//////////////////////////////////////////////////

	// no expected number exists before the first syn
	always_ff @(posedge CLOCK) begin
		if (rst) begin
			synSeen <= 1'b0;
			gapped  <= 1'b0;
		end else if (segValid) begin
			if (segSyn) begin
				synSeen <= 1'b1;
				gapped  <= 1'b0;
			end else begin
				gapped <= synSeen && seqMiss;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/tcpStream.sv */
`timescale 1ns/1ps
`default_nettype none

module tcpStream #(
	parameter int fifoDepth = 64
) (
	input  wire                  CLOCK,
	input  wire                  rst,
	input  wire                  newPkt,
	input  wire                  dataValid,
	input  wire tcpStreamPkg::byteT   data,
	input  wire tcpStreamPkg::ipAddrT srcIp,
	input  wire tcpStreamPkg::portT   srcPort,
	input  wire tcpStreamPkg::ipAddrT dstIp,
	input  wire tcpStreamPkg::portT   dstPort,
	input  wire                  outReady,
	output logic                 outValid,
	output tcpStreamPkg::byteT   outData,
	output logic                 outFirst,
	output logic                 dropped,
	output logic                 gapped
);

	import tcpStreamPkg::*;

	// parser to fifo
	logic   payValid;
	byteT   payData;
	logic   payFirst;

	// parser to sequence tracker
	logic   segValid;
	seqNumT segSeq;
	logic   segSyn;
	lenT    segLen;

	frameParser frameParser_i (
		.CLOCK(CLOCK), .rst(rst),
		.newPkt(newPkt), .dataValid(dataValid), .data(data),
		.srcIp(srcIp), .dstIp(dstIp), .srcPort(srcPort), .dstPort(dstPort),
		.payValid(payValid), .payData(payData), .payFirst(payFirst),
		.segValid(segValid), .segSeq(segSeq), .segSyn(segSyn), .segLen(segLen)
	);

	payloadFifo #(.fifoDepth(fifoDepth)) payloadFifo_i (
		.CLOCK(CLOCK), .rst(rst),
		.payValid(payValid), .payData(payData), .payFirst(payFirst),
		.outReady(outReady), .outValid(outValid), .outData(outData),
		.outFirst(outFirst), .dropped(dropped)
	);

	seqTracker seqTracker_i (
		.CLOCK(CLOCK), .rst(rst),
		.segValid(segValid), .segSeq(segSeq), .segSyn(segSyn), .segLen(segLen),
		.gapped(gapped)
	);

endmodule

`default_nettype wire

/* tb/tbFrames.svh */
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

// next frame's fields, filled in before buildFrame
logic        fVlan;
logic [15:0] fEthType;
logic [7:0]  fProto;
logic [31:0] fSrcIp;
logic [31:0] fDstIp;
logic [15:0] fSrcPort;
logic [15:0] fDstPort;
logic [31:0] fSeq;
logic        fSyn;
int          fPayLen;

logic [7:0] frameBytes[$];	// whole frame, mac first
logic [7:0] payloadBytes[$];	// tcp payload alone

// msb first as on the wire
task automatic pushBytes(input logic [31:0] value, input int count);
	for (int i = count - 1; i >= 0; i--)
		frameBytes.push_back(value[i*8 +: 8]);
endtask

task automatic buildFrame();
	int ipOptWords;
	int tcpOptWords;
	ipOptWords  = $urandom % 3;
	tcpOptWords = $urandom % 4;
	frameBytes.delete();
	payloadBytes.delete();
	pushBytes($urandom, 4);	// dst and src mac
	pushBytes($urandom, 4);
	pushBytes($urandom, 4);
	if (fVlan) begin
		pushBytes(32'h8100, 2);
		pushBytes($urandom % 4096, 2);	// vid only
	end
	pushBytes(fEthType, 2);

	// ipv4 header with nop options
	pushBytes({4'h4, 4'(5 + ipOptWords)}, 1);
	pushBytes(8'h00, 1);
	pushBytes(40 + 4 * (ipOptWords + tcpOptWords) + fPayLen, 2);	// total length
	pushBytes($urandom, 2);
	pushBytes(16'h4000, 2);	// no fragments
	pushBytes({8'd64, fProto}, 2);	// ttl and protocol
	pushBytes($urandom, 2);	// header checksum not checked
	pushBytes(fSrcIp, 4);
	pushBytes(fDstIp, 4);
	repeat (ipOptWords) pushBytes(32'h0101_0101, 4);

	// tcp header
	pushBytes({fSrcPort, fDstPort}, 4);
	pushBytes(fSeq, 4);
	pushBytes($urandom, 4);	// ack number
	pushBytes({4'(5 + tcpOptWords), 4'h0, fSyn ? 8'h02 : 8'h10}, 2);
	pushBytes($urandom, 2);	// window
	pushBytes($urandom, 4);	// checksum and urgent pointer
	repeat (tcpOptWords) pushBytes(32'h0101_0101, 4);

	for (int i = 0; i < fPayLen; i++)
		payloadBytes.push_back(8'($urandom));
	foreach (payloadBytes[i])
		frameBytes.push_back(payloadBytes[i]);
	pushBytes($urandom, 4);	// fcs ignored by the parser
endtask

`endif

/* tb/tcpStreamTb.sv */
`timescale 1ns/1ps
`default_nettype none

module tcpStreamTb;

	import tcpStreamPkg::*;

	localparam int     FIFO_DEPTH    = 64;	// dut default
	localparam int     NUM_RANDOM    = 80;
	localparam int     NUM_FRAMES    = NUM_RANDOM + 14;
	localparam int     WATCH_CYCLES  = NUM_FRAMES * 200 + 1000;
	localparam ipAddrT SESS_SRC_IP   = 32'hc0a8_0a05;
	localparam ipAddrT SESS_DST_IP   = 32'h0a00_0217;
	localparam portT   SESS_SRC_PORT = 16'd49321;
	localparam portT   SESS_DST_PORT = 16'd443;

	logic   CLOCK;
	logic   rst;
	logic   newPkt;
	logic   dataValid;
	byteT   data;
	logic   outReady;
	logic   outValid;
	byteT   outData;
	logic   outFirst;
	logic   dropped;
	logic   gapped;

	logic [8:0] expQ[$];	// {first tag, byte}
	logic [8:0] headExp;
	logic       mdlSynSeen;
	seqNumT     mdlExpSeq;
	logic       mdlGap;
	logic       mdlDropped;
	seqNumT     txSeq;		// sender's next sequence number
	logic       stallOut;
	logic       prevStall;
	byteT       prevData;
	logic       prevFirst;
	int         errCnt;
	int         checkCnt;

	`include "tbFrames.svh"

	tcpStream tcpStream_i (
		.CLOCK(CLOCK), .rst(rst),
		.newPkt(newPkt), .dataValid(dataValid), .data(data),
		.srcIp(SESS_SRC_IP), .srcPort(SESS_SRC_PORT),
		.dstIp(SESS_DST_IP), .dstPort(SESS_DST_PORT),
		.outReady(outReady), .outValid(outValid), .outData(outData),
		.outFirst(outFirst), .dropped(dropped), .gapped(gapped)
	);

	initial begin
		CLOCK = 1'b0;
		forever #2 CLOCK = ~CLOCK;
	end

	// sink stalls a quarter of the time
	always @(posedge CLOCK) begin
		#1;
		outReady = stallOut ? 1'b0 : ($urandom % 4 != 0);
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge CLOCK);
		$display("timeout after %0d cycles, the run never reached its end", WATCH_CYCLES);
		$display("%0d checks, %0d errors", checkCnt, errCnt);
		$display("Finished with errors");
		$finish;
	end

	//////////////////////////////////////////////////
	// checks and model
	//////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCnt++;
		assert (got === exp) else begin
			errCnt++;
			$display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic checkTrue(input bit cond, input string what);
		checkCnt++;
		assert (cond) else begin
			errCnt++;
			$display("ERROR at %0d ns: %s", $time, what);
		end
	endtask

	// sampled mid-cycle, a transfer happens at the next rising edge
	always @(negedge CLOCK) begin
		if (rst) begin
			prevStall = 1'b0;
		end else begin
			if (prevStall) begin
				checkTrue(outValid, "outValid fell before the byte was taken");
				checkValue("outData", outData, prevData);
				checkValue("outFirst", outFirst, prevFirst);
			end
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					checkTrue(1'b0, "output byte arrived with no payload byte expected");
				end else begin
					headExp = expQ.pop_front();
					checkValue("outData", outData, headExp[7:0]);
					checkValue("outFirst", outFirst, headExp[8]);
				end
			end
			prevStall = outValid && !outReady;
			prevData  = outData;
			prevFirst = outFirst;
		end
	end

	task automatic setMatching(input seqNumT seq, input logic syn, input int len);
		fVlan    = 1'($urandom % 2);
		fEthType = 16'h0800;
		fProto   = 8'd6;
		fSrcIp   = SESS_SRC_IP;
		fDstIp   = SESS_DST_IP;
		fSrcPort = SESS_SRC_PORT;
		fDstPort = SESS_DST_PORT;
		fSeq     = seq;
		fSyn     = syn;
		fPayLen  = len;
	endtask

	// one field off the session or not tcp over ipv4
	task automatic spoilField(input int which);
		case (which)
			0: fSrcIp = fSrcIp ^ (32'd1 << ($urandom % 32));
			1: fDstIp = fDstIp ^ (32'd1 << ($urandom % 32));
			2: fSrcPort = fSrcPort ^ (16'd1 << ($urandom % 16));
			3: fDstPort = fDstPort ^ (16'd1 << ($urandom % 16));
			4: fEthType = 16'h0806;	// arp
			5: fEthType = 16'h86dd;	// ipv6
			default: fProto = 8'd17;	// udp
		endcase
	endtask

	task automatic driveFrame();
		int idx;
		idx = 0;
		@(posedge CLOCK);
		#1;
		newPkt = 1'b1;
		@(posedge CLOCK);
		#1;
		newPkt = 1'b0;
		while (idx < frameBytes.size()) begin
			if ($urandom % 4 == 0) begin
				dataValid = 1'b0;
				data      = 8'($urandom);
			end else begin
				dataValid = 1'b1;
				data      = frameBytes[idx];
				idx++;
			end
			@(posedge CLOCK);
			#1;
		end
		dataValid = 1'b0;
	endtask

	task automatic waitIdle();
		int quiet;
		quiet = 0;
		while (quiet < 4) begin
			@(negedge CLOCK);
			quiet = outValid ? 0 : quiet + 1;
		end
	endtask

	task automatic runFrame(input logic stall);
		logic match;
		int   keep;
		buildFrame();
		match = fEthType == 16'h0800 && fProto == 8'd6 && fSrcIp == SESS_SRC_IP &&
			fDstIp == SESS_DST_IP && fSrcPort == SESS_SRC_PORT && fDstPort == SESS_DST_PORT;
		if (match) begin
			keep = (stall && fPayLen > FIFO_DEPTH) ? FIFO_DEPTH : fPayLen;
			for (int i = 0; i < keep; i++)
				expQ.push_back({i == 0, payloadBytes[i]});
			if (keep < fPayLen)
				mdlDropped = 1'b1;	// tail lost to a full fifo
			if (fSyn) begin
				mdlSynSeen = 1'b1;
				mdlGap     = 1'b0;
				mdlExpSeq  = fSeq + 1;
			end else begin
				mdlGap    = mdlSynSeen && fSeq != mdlExpSeq;
				mdlExpSeq = fSeq + seqNumT'(fPayLen);
			end
		end
		stallOut = stall;
		driveFrame();
		repeat (3) @(posedge CLOCK);	// last byte into the fifo
		stallOut = 1'b0;
		waitIdle();
		checkTrue(expQ.size() == 0, "payload bytes of a matching frame never came out");
		expQ.delete();
		checkValue("gapped", gapped, mdlGap);
		checkValue("dropped", dropped, mdlDropped);
	endtask

	task automatic checkIdleAfterReset();
		@(negedge CLOCK);
		checkValue("outValid", outValid, 1'b0);
		checkValue("dropped", dropped, 1'b0);
		checkValue("gapped", gapped, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		seqNumT base;
		int     kind;
		int     len;
		void'($urandom(32'h9e45));
		rst        = 1'b1;
		newPkt     = 1'b0;
		dataValid  = 1'b0;
		data       = '0;
		outReady   = 1'b0;
		stallOut   = 1'b0;
		prevStall  = 1'b0;
		prevData   = '0;
		prevFirst  = 1'b0;
		mdlSynSeen = 1'b0;
		mdlExpSeq  = '0;
		mdlGap     = 1'b0;
		mdlDropped = 1'b0;
		errCnt     = 0;
		checkCnt   = 0;
		repeat (5) @(posedge CLOCK);
		#1;
		rst = 1'b0;
		checkIdleAfterReset();

		// syn, in order, pure ack, skip, resync
		base = $urandom;
		setMatching(base, 1'b1, 0);
		runFrame(1'b0);
		checkValue("gapped", gapped, 1'b0);
		setMatching(base + 1, 1'b0, 10);
		runFrame(1'b0);
		setMatching(base + 11, 1'b0, 0);
		runFrame(1'b0);
		setMatching(base + 11, 1'b0, 25);
		runFrame(1'b0);
		checkValue("gapped", gapped, 1'b0);
		setMatching(base + 136, 1'b0, 15);	// 100 numbers skipped
		runFrame(1'b0);
		checkValue("gapped", gapped, 1'b1);
		setMatching(base + 151, 1'b0, 5);
		runFrame(1'b0);
		checkValue("gapped", gapped, 1'b0);
		txSeq = base + 156;

		for (int k = 0; k < 7; k++) begin
			setMatching(txSeq, 1'b0, 20);
			spoilField(k);
			runFrame(1'b0);
		end

		for (int n = 0; n < NUM_RANDOM; n++) begin
			kind = $urandom % 10;
			len  = ($urandom % 6 == 0) ? 0 : $urandom % 41;
			if (kind == 0)
				setMatching($urandom, 1'b1, 0);
			else if (kind == 1)
				setMatching(txSeq + 1 + $urandom % 500, 1'b0, len);
			else
				setMatching(txSeq, 1'b0, len);
			if (kind == 2 || kind == 3)
				spoilField($urandom % 7);
			runFrame(1'b0);
			if (kind < 2 || kind > 3)
				txSeq = fSyn ? fSeq + 1 : fSeq + seqNumT'(fPayLen);
		end

		// sink stalled through a frame longer than the fifo
		setMatching(txSeq, 1'b0, 80);
		runFrame(1'b1);
		checkValue("dropped", dropped, 1'b1);

		@(posedge CLOCK);
		#1;
		rst = 1'b1;
		repeat (5) @(posedge CLOCK);
		#1;
		rst = 1'b0;
		checkIdleAfterReset();

		$display("%0d checks, %0d errors", checkCnt, errCnt);
		if (errCnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* tcpStream.f */
+incdir+tb
verilog/tcpStreamPkg.sv
verilog/frameParser.sv
verilog/payloadFifo.sv
verilog/seqTracker.sv
verilog/tcpStream.sv
tb/tcpStreamTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tcpStreamTb
RTL_TOP   ?= tcpStream
FILELIST  ?= tcpStream.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
